// File: verilog.f
hw/fsqrt_pkg.sv
hw/sqrt_operand_prep.sv
hw/sqrt_recurrence.sv
hw/sqrt_round_pack.sv
hw/sqrt_control.sv
hw/fsqrt_top.sv
tests/fsqrt_properties.sv
tests/tb_fsqrt.sv

// File: Makefile
TOP := tb_fsqrt

.PHONY: sim clean

# Build and run; a $fatal or a failed assertion gives a nonzero exit status
sim:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f verilog.f
	./obj_dir/V$(TOP)

clean:
	rm -rf obj_dir

// File: tests/sqrt_cases.txt
# operand mode expected_result expected_flags, all hex
# mode 0..4 = RNE RTZ RDN RUP RMM, flags = {nv dz of uf nx}
40800000 0 40000000 00
40800000 1 40000000 00
40800000 2 40000000 00
40800000 3 40000000 00
40800000 4 40000000 00
40100000 0 3fc00000 00
41100000 3 40400000 00
40000000 0 3fb504f3 01
40000000 1 3fb504f3 01
40000000 2 3fb504f3 01
40000000 3 3fb504f4 01
40000000 4 3fb504f3 01
40400000 0 3fddb3d7 01
40400000 3 3fddb3d8 01
40a00000 0 400f1bbd 01
40a00000 1 400f1bbc 01
40a00000 4 400f1bbd 01
7f7fffff 0 5f7fffff 01
7f7fffff 3 5f800000 01
7fc00000 0 7fc00000 00
7f800001 0 7fc00000 10
bf800000 0 7fc00000 10
ff800000 2 7fc00000 10
7f800000 0 7f800000 00
00000000 0 00000000 00
80000000 1 80000000 00
00000001 0 1a3504f3 01
007fffff 0 1fffffff 01
007fffff 1 1ffffffe 01
00200000 0 1f800000 00

// File: tests/tb_fsqrt.sv
`timescale 1ns/1ps

module tb_fsqrt;

  import fsqrt_pkg::*;

  localparam int CLK_NS       = 100;
  localparam int RESET_CYCLES = 10;
  // Edges from capture to o_valid
  localparam int LAT_NORMAL   = 30;
  localparam int LAT_SPECIAL  = 2;

  logic        i_clk = 1'b0;
  logic        i_rst;
  logic        i_valid;
  fp32_t       i_operand;
  round_mode_e i_rounding_mode;
  fp32_t       o_result;
  fp_flags_t   o_flags;
  logic        o_valid;
  logic        o_stall;

  // Case table from the data file
  fp32_t       case_op[$];
  round_mode_e case_rm[$];
  fp32_t       case_res[$];
  fp_flags_t   case_flags[$];
  int          num_cases;
  logic        cases_loaded = 1'b0;
  int          cur_case;
  logic [31:0] rng_state;

  // Last completed result, must hold until the next one
  fp32_t       last_res;
  fp_flags_t   last_flags;
  logic        have_result;

  always #(CLK_NS / 2) i_clk = ~i_clk;

  fsqrt_top u_fsqrt_top (
    .i_clk           (i_clk),
    .i_rst           (i_rst),
    .i_valid         (i_valid),
    .i_operand       (i_operand),
    .i_rounding_mode (i_rounding_mode),
    .o_result        (o_result),
    .o_flags         (o_flags),
    .o_valid         (o_valid),
    .o_stall         (o_stall)
  );

  // ==========================================================
  // Helpers
  // ==========================================================

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // NaN, inf, zero or any negative value takes the early-out path
  function automatic bit is_special_operand(input fp32_t op);
    return (op.exp == 8'hFF) || (op.exp == 8'h00 && op.frac == '0) || op.sign;
  endfunction

  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("CHECKS FAILED");
    $fatal(1, "run stopped");
  endtask

  task automatic check_result(input fp32_t got, input fp32_t want);
    if (got !== want) begin
      fail_run($sformatf("mismatch o_result case %0d: got 0x%08h expected 0x%08h",
                         cur_case, got, want));
    end
  endtask

  task automatic check_flags(input fp_flags_t got, input fp_flags_t want);
    if (got !== want) begin
      fail_run($sformatf("mismatch o_flags case %0d: got 0x%02h expected 0x%02h",
                         cur_case, got, want));
    end
  endtask

  task automatic load_cases();
    int          fd;
    int          n;
    string       line;
    logic [31:0] op;
    logic [31:0] res;
    logic [2:0]  rm;
    logic [4:0]  flg;
    fd = $fopen("tests/sqrt_cases.txt", "r");
    if (fd == 0) begin
      fail_run("cannot open tests/sqrt_cases.txt");
    end
    while (!$feof(fd)) begin
      line = "";
      void'($fgets(line, fd));
      // Skip blank and comment lines
      if (line.len() > 1 && line.getc(0) != "#") begin
        n = $sscanf(line, "%h %h %h %h", op, rm, res, flg);
        if (n != 4) begin
          fail_run($sformatf("unreadable line in the case file: %s", line));
        end
        case_op.push_back(fp32_t'(op));
        case_rm.push_back(round_mode_e'(rm));
        case_res.push_back(fp32_t'(res));
        case_flags.push_back(fp_flags_t'(flg));
      end
    end
    $fclose(fd);
    num_cases = case_op.size();
    if (num_cases == 0) begin
      fail_run("the case file holds no cases");
    end
  endtask

  // One request, with a random idle gap and optional busy noise
  task automatic run_case(
    input fp32_t       op,
    input round_mode_e rm,
    input fp32_t       want_res,
    input fp_flags_t   want_flags
  );
    int   gap;
    int   edges;
    int   want_lat;
    logic noise;
    logic done;
    rng_state = xorshift32(rng_state);
    gap       = int'(rng_state[1:0]);
    noise     = rng_state[4];
    want_lat  = is_special_operand(op) ? LAT_SPECIAL : LAT_NORMAL;
    repeat (gap) @(negedge i_clk);
    if (have_result) begin
      check_result(o_result, last_res);
      check_flags(o_flags, last_flags);
    end
    i_valid         = 1'b1;
    i_operand       = op;
    i_rounding_mode = rm;
    #1;
    // Stall follows the request unless a result is showing
    if (o_valid === 1'b0 && o_stall !== 1'b1) begin
      fail_run("o_stall stayed low while a request was pending");
    end
    edges = -1;
    done  = 1'b0;
    while (!done) begin
      @(posedge i_clk);
      edges++;
      @(negedge i_clk);
      if (o_valid === 1'b1 || edges == want_lat) begin
        done = 1'b1;
      end else if (o_stall !== 1'b1) begin
        fail_run("o_stall fell before o_valid");
      end
      if (edges == 0 && noise) begin
        // Another request while busy, the DUT must drop it
        i_operand       = ~op;
        i_rounding_mode = (rm == RUP) ? RTZ : RUP;
      end else begin
        i_valid = 1'b0;
      end
    end
    if (edges != want_lat) begin
      fail_run($sformatf("mismatch o_valid latency case %0d: got 0x%0h expected 0x%0h",
                         cur_case, edges, want_lat));
    end
    if (o_valid !== 1'b1) begin
      fail_run("o_valid did not rise at the fixed latency");
    end
    if (o_stall !== 1'b0) begin
      fail_run("o_stall high while o_valid is high");
    end
    check_result(o_result, want_res);
    check_flags(o_flags, want_flags);
    last_res    = want_res;
    last_flags  = want_flags;
    have_result = 1'b1;
  endtask

  // ==========================================================
  // Stimulus and watchdog
  // ==========================================================

  initial begin : stimulus
    i_rst           = 1'b1;
    i_valid         = 1'b0;
    i_operand       = '0;
    i_rounding_mode = RNE;
    rng_state       = 32'd47;
    have_result     = 1'b0;
    cur_case        = -1;
    load_cases();
    cases_loaded = 1'b1;
    repeat (RESET_CYCLES) @(posedge i_clk);
    @(negedge i_clk);
    i_rst = 1'b0;
    // Outputs cleared by reset
    if (o_valid !== 1'b0 || o_stall !== 1'b0) begin
      fail_run("o_valid or o_stall high after reset");
    end
    check_result(o_result, '0);
    check_flags(o_flags, '0);
    for (int n = 0; n < num_cases; n++) begin
      cur_case = n;
      run_case(case_op[n], case_rm[n], case_res[n], case_flags[n]);
    end
    @(negedge i_clk);
    $display("ALL CHECKS PASSED");
    $finish;
  end

  // Budget of 40 cycles per case plus reset
  initial begin : watchdog
    wait (cases_loaded == 1'b1);
    #(((num_cases + 2) * 40 + RESET_CYCLES) * CLK_NS);
    $display("timeout: the DUT did not finish all cases in the expected time");
    $display("CHECKS FAILED");
    $fatal(1, "watchdog expired");
  end

endmodule

// File: tests/fsqrt_properties.sv
`timescale 1ns/1ps

module fsqrt_properties (
  input logic i_clk,
  input logic i_rst,
  input logic i_result_valid,
  input logic i_stall
);

  // ==========================================================
  // Result strobe and stall
  // ==========================================================

  // One operation in flight, so the strobe is a single-cycle pulse
  valid_single_pulse: assert property (
    @(posedge i_clk) disable iff (i_rst) i_result_valid |=> !i_result_valid
  ) else $error("o_valid stayed high for two cycles");

  // Requester is released in the cycle the result is presented
  stall_low_with_valid: assert property (
    @(posedge i_clk) disable iff (i_rst) i_result_valid |-> !i_stall
  ) else $error("o_stall high together with o_valid");

  // No stale strobe once reset lets go
  valid_low_after_reset: assert property (
    @(posedge i_clk) $fell(i_rst) |-> !i_result_valid
  ) else $error("o_valid high in the first cycle after reset");

endmodule

// Attach to every instance of the top level
bind fsqrt_top fsqrt_properties u_fsqrt_properties (
  .i_clk          (i_clk),
  .i_rst          (i_rst),
  .i_result_valid (o_valid),
  .i_stall        (o_stall)
);

// File: hw/fsqrt_top.sv
`timescale 1ns/1ps

module fsqrt_top (
  input  logic                   i_clk,
  input  logic                   i_rst,
  input  logic                   i_valid,
  input  fsqrt_pkg::fp32_t       i_operand,
  input  fsqrt_pkg::round_mode_e i_rounding_mode,
  output fsqrt_pkg::fp32_t       o_result,
  output fsqrt_pkg::fp_flags_t   o_flags,
  output logic                   o_valid,
  output logic                   o_stall
);

  import fsqrt_pkg::*;

  // Captured operation
  fp32_t                   operand;
  round_mode_e             rm;
  logic [EXP_EXT_BITS-1:0] exp;

  // Prep outputs
  sqrt_job_t job;
  special_t  special;

  // Recurrence
  logic                 load;
  logic [ROOT_BITS-1:0] root;
  logic                 sticky;
  logic                 last;

  // Rounder outputs
  fp32_t     round_result;
  fp_flags_t round_flags;

  sqrt_control u_control (
    .i_clk           (i_clk),
    .i_rst           (i_rst),
    .i_valid         (i_valid),
    .i_operand       (i_operand),
    .i_rounding_mode (i_rounding_mode),
    .i_special       (special),
    .i_job           (job),
    .i_last          (last),
    .i_round_result  (round_result),
    .i_round_flags   (round_flags),
    .o_operand       (operand),
    .o_rm            (rm),
    .o_exp           (exp),
    .o_load          (load),
    .o_result        (o_result),
    .o_flags         (o_flags),
    .o_valid         (o_valid),
    .o_stall         (o_stall)
  );

  sqrt_operand_prep u_operand_prep (
    .i_operand (operand),
    .o_job     (job),
    .o_special (special)
  );

  // Radicand is the scaled mantissa from prep
  sqrt_recurrence u_recurrence (
    .i_clk    (i_clk),
    .i_rst    (i_rst),
    .i_load   (load),
    .i_mant   (job.mant),
    .o_root   (root),
    .o_sticky (sticky),
    .o_last   (last)
  );

  sqrt_round_pack u_round_pack (
    .i_root   (root),
    .i_sticky (sticky),
    .i_exp    (exp),
    .i_rm     (rm),
    .o_result (round_result),
    .o_flags  (round_flags)
  );

endmodule

// File: hw/sqrt_control.sv
`timescale 1ns/1ps

module sqrt_control (
  input  logic                               i_clk,
  input  logic                               i_rst,
  input  logic                               i_valid,
  input  fsqrt_pkg::fp32_t                   i_operand,
  input  fsqrt_pkg::round_mode_e             i_rounding_mode,
  input  fsqrt_pkg::special_t                i_special,
  input  fsqrt_pkg::sqrt_job_t               i_job,
  input  logic                               i_last,
  input  fsqrt_pkg::fp32_t                   i_round_result,
  input  fsqrt_pkg::fp_flags_t               i_round_flags,
  output fsqrt_pkg::fp32_t                   o_operand,
  output fsqrt_pkg::round_mode_e             o_rm,
  output logic [fsqrt_pkg::EXP_EXT_BITS-1:0] o_exp,
  output logic                               o_load,
  output fsqrt_pkg::fp32_t                   o_result,
  output fsqrt_pkg::fp_flags_t               o_flags,
  output logic                               o_valid,
  output logic                               o_stall
);

  import fsqrt_pkg::*;

  sqrt_state_e state;
  sqrt_state_e state_next;

  // Captured operation
  fp32_t                   operand_q;
  round_mode_e             rm_q;
  logic [EXP_EXT_BITS-1:0] exp_q;

  // Completed result
  fp32_t     result_q;
  fp_flags_t flags_q;
  fp_flags_t special_flags;
  logic      valid_q;

  // ==========================================================
  // FSM
  // ==========================================================

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      state <= IDLE;
    end else begin
      state <= state_next;
    end
  end

  always_comb begin
    state_next = state;
    case (state)
      // New requests are only looked at here
      IDLE:    if (i_valid) state_next = PREP;
      // Special operands skip the recurrence
      PREP:    state_next = i_special.is_special ? DONE : COMPUTE;
      COMPUTE: if (i_last) state_next = ROUND;
      ROUND:   state_next = DONE;
      DONE:    state_next = IDLE;
      default: state_next = IDLE;
    endcase
  end

  // ==========================================================
  // Operand and job registers
  // ==========================================================

  always_ff @(posedge i_clk) begin
    if (state == IDLE && i_valid) begin
      operand_q <= i_operand;
      rm_q      <= i_rounding_mode;
    end
    // Exponent is held for the rounder while the root is built
    if (state == PREP) begin
      exp_q <= i_job.exp;
    end
  end

  // Start the recurrence in the same cycle the exponent is stored
  assign o_load = (state == PREP) && !i_special.is_special;

  // ==========================================================
  // Result registers
  // ==========================================================

  always_comb begin
    special_flags    = '0;
    special_flags.nv = i_special.invalid;
  end

  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      result_q <= '0;
      flags_q  <= '0;
      valid_q  <= 1'b0;
    end else begin
      // Single-cycle pulse once DONE is left
      valid_q <= (state == DONE);
      if (state == PREP && i_special.is_special) begin
        result_q <= i_special.result;
        flags_q  <= special_flags;
      end else if (state == ROUND) begin
        result_q <= i_round_result;
        flags_q  <= i_round_flags;
      end
    end
  end

  assign o_operand = operand_q;
  assign o_rm      = rm_q;
  assign o_exp     = exp_q;
  assign o_result  = result_q;
  assign o_flags   = flags_q;
  assign o_valid   = valid_q;
  // Stall from the request cycle until the result is presented
  assign o_stall   = ((state != IDLE) || i_valid) && !valid_q;

endmodule

// File: hw/sqrt_round_pack.sv
`timescale 1ns/1ps

module sqrt_round_pack (
  input  logic [fsqrt_pkg::ROOT_BITS-1:0]    i_root,
  input  logic                               i_sticky,
  input  logic [fsqrt_pkg::EXP_EXT_BITS-1:0] i_exp,
  input  fsqrt_pkg::round_mode_e             i_rm,
  output fsqrt_pkg::fp32_t                   o_result,
  output fsqrt_pkg::fp_flags_t               o_flags
);

  import fsqrt_pkg::*;

  logic [MANT_BITS-1:0]    mant;
  logic                    lsb;
  logic                    guard;
  logic                    sticky;
  logic                    round_up;
  logic [MANT_BITS:0]      mant_rnd;
  logic                    carry;
  logic [EXP_EXT_BITS-1:0] exp_rnd;

  // Root MSB is the hidden bit, always set
  assign mant   = i_root[ROOT_BITS-1 -: MANT_BITS];
  assign lsb    = mant[0];
  assign guard  = i_root[2];
  // Low root bits and the leftover remainder fold into sticky
  assign sticky = i_root[1] | i_root[0] | i_sticky;

  // ==========================================================
  // Round-up decision, result sign is always positive
  // ==========================================================

  always_comb begin
    case (i_rm)
      RNE:     round_up = guard & (sticky | lsb);
      RTZ:     round_up = 1'b0;
      // Toward minus inf truncates a positive value
      RDN:     round_up = 1'b0;
      RUP:     round_up = guard | sticky;
      RMM:     round_up = guard;
      default: round_up = 1'b0;
    endcase
  end

  // ==========================================================
  // Increment and pack
  // ==========================================================

  assign mant_rnd = {1'b0, mant} + {{MANT_BITS{1'b0}}, round_up};
  // Carry out means 10.000..., fraction field is zero either way
  assign carry    = mant_rnd[MANT_BITS];
  assign exp_rnd  = i_exp + {{(EXP_EXT_BITS - 1){1'b0}}, carry};

  assign o_result.sign = 1'b0;
  // No overflow or underflow possible, low byte is the biased exponent
  assign o_result.exp  = exp_rnd[EXP_BITS-1:0];
  assign o_result.frac = mant_rnd[FRAC_BITS-1:0];

  assign o_flags.nv = 1'b0;
  assign o_flags.dz = 1'b0;
  assign o_flags.of = 1'b0;
  assign o_flags.uf = 1'b0;
  assign o_flags.nx = guard | sticky;

endmodule

// File: hw/sqrt_recurrence.sv
`timescale 1ns/1ps

module sqrt_recurrence (
  input  logic                            i_clk,
  input  logic                            i_rst,
  input  logic                            i_load,
  input  logic [fsqrt_pkg::MANT_BITS:0]   i_mant,
  output logic [fsqrt_pkg::ROOT_BITS-1:0] o_root,
  output logic                            o_sticky,
  output logic                            o_last
);

  import fsqrt_pkg::*;

  // Counter value once all root bits are out
  localparam logic [COUNT_BITS-1:0] ITER_END = COUNT_BITS'(ROOT_BITS);

  logic [ROOT_BITS-1:0]  root;
  logic [REM_BITS-1:0]   remainder;
  logic [RAD_BITS-1:0]   radicand;
  logic [COUNT_BITS-1:0] count;

  logic                  running;
  logic [REM_BITS-1:0]   rem_cand;
  logic [REM_BITS-1:0]   trial;
  logic                  rem_ge;

  assign running = (count != ITER_END);

  // Bring down the next two radicand bits
  assign rem_cand = {remainder[REM_BITS-3:0], radicand[RAD_BITS-1 -: 2]};
  // Trial divisor is the partial root with 01 appended
  assign trial    = {{(REM_BITS - ROOT_BITS - 2){1'b0}}, root, 2'b01};
  assign rem_ge   = (rem_cand >= trial);

  // Iteration counter, idles at the end value out of reset
  always_ff @(posedge i_clk) begin
    if (i_rst) begin
      count <= ITER_END;
    end else if (i_load) begin
      count <= '0;
    end else if (running) begin
      count <= count + 1'b1;
    end
  end

  // Root, remainder and radicand
  always_ff @(posedge i_clk) begin
    if (i_load) begin
      root      <= '0;
      remainder <= '0;
      // Left-align so the two integer bits come down first
      radicand  <= {i_mant, {(RAD_BITS - MANT_BITS - 1){1'b0}}};
    end else if (running) begin
      radicand <= {radicand[RAD_BITS-3:0], 2'b00};
      if (rem_ge) begin
        remainder <= rem_cand - trial;
        root      <= {root[ROOT_BITS-2:0], 1'b1};
      end else begin
        remainder <= rem_cand;
        root      <= {root[ROOT_BITS-2:0], 1'b0};
      end
    end
  end

  assign o_root   = root;
  // Any leftover remainder means the root is inexact
  assign o_sticky = |remainder;
  assign o_last   = (count == ITER_END - 1'b1);

endmodule

// File: hw/sqrt_operand_prep.sv
`timescale 1ns/1ps

module sqrt_operand_prep (
  input  fsqrt_pkg::fp32_t     i_operand,
  output fsqrt_pkg::sqrt_job_t o_job,
  output fsqrt_pkg::special_t  o_special
);

  import fsqrt_pkg::*;

  // Operand classification
  logic is_zero;
  logic is_subnormal;
  logic is_inf;
  logic is_nan;
  logic is_snan;

  // Normalization of subnormals
  logic [4:0]                     frac_lzc;
  logic [4:0]                     norm_shift;
  logic signed [EXP_EXT_BITS-1:0] exp_adj;
  logic [MANT_BITS-1:0]           mant_norm;

  // Exponent halving
  logic                           odd_exp;
  logic signed [EXP_EXT_BITS-1:0] exp_sum;

  assign is_zero      = (i_operand.exp == '0) && (i_operand.frac == '0);
  assign is_subnormal = (i_operand.exp == '0) && (i_operand.frac != '0);
  assign is_inf       = (i_operand.exp == '1) && (i_operand.frac == '0);
  assign is_nan       = (i_operand.exp == '1) && (i_operand.frac != '0);
  // Signaling NaN has the quiet bit clear
  assign is_snan      = is_nan && !i_operand.frac[FRAC_BITS-1];

  // ==========================================================
  // Leading-zero count of the fraction
  // ==========================================================

  // Scan upward so the highest set bit wins
  always_comb begin
    frac_lzc = '0;
    for (int i = 0; i < FRAC_BITS; i++) begin
      if (i_operand.frac[i]) begin
        frac_lzc = 5'(FRAC_BITS - 1 - i);
      end
    end
  end

  // One extra shift moves the leading one into the hidden bit
  assign norm_shift = frac_lzc + 5'd1;

  always_comb begin
    if (is_subnormal) begin
      // Biased exponent becomes 1 - norm_shift = -lzc
      exp_adj   = -$signed({5'b0, frac_lzc});
      mant_norm = {1'b0, i_operand.frac} << norm_shift;
    end else begin
      exp_adj   = $signed({2'b00, i_operand.exp});
      mant_norm = {1'b1, i_operand.frac};
    end
  end

  // ==========================================================
  // Exponent halving and mantissa scaling
  // ==========================================================

  // Bias is odd, so an even biased exponent means an odd unbiased one
  assign odd_exp = ~exp_adj[0];

  // Odd case drops one from the sum and doubles the mantissa instead
  assign exp_sum = odd_exp ? exp_adj + EXP_EXT_BITS'(EXP_BIAS - 1)
                           : exp_adj + EXP_EXT_BITS'(EXP_BIAS);

  assign o_job.mant = odd_exp ? {mant_norm, 1'b0} : {1'b0, mant_norm};
  // Arithmetic shift keeps the rebias exact
  assign o_job.exp  = exp_sum >>> 1;

  // ==========================================================
  // Special cases
  // ==========================================================

  always_comb begin
    o_special = '0;
    if (is_nan) begin
      // Only a signaling NaN raises invalid
      o_special.is_special = 1'b1;
      o_special.invalid    = is_snan;
      o_special.result     = CANONICAL_NAN;
    end else if (i_operand.sign && !is_zero) begin
      // Negative number, including -inf
      o_special.is_special = 1'b1;
      o_special.invalid    = 1'b1;
      o_special.result     = CANONICAL_NAN;
    end else if (is_inf) begin
      o_special.is_special = 1'b1;
      o_special.result     = '{sign: 1'b0, exp: '1, frac: '0};
    end else if (is_zero) begin
      // Zero keeps its sign
      o_special.is_special  = 1'b1;
      o_special.result.sign = i_operand.sign;
    end
  end

endmodule

// File: hw/fsqrt_pkg.sv
package fsqrt_pkg;

  // ==========================================================
  // Format widths
  // ==========================================================

  // IEEE 754 binary32 fields
  localparam int unsigned EXP_BITS = 8;
  localparam int unsigned FRAC_BITS = 23;
  // Significand with hidden bit
  localparam int unsigned MANT_BITS = FRAC_BITS + 1;

  // Root bits: 24 mantissa bits plus guard room
  localparam int unsigned ROOT_BITS = MANT_BITS + 3;
  // Two radicand bits consumed per root bit
  localparam int unsigned RAD_BITS = 2 * ROOT_BITS;
  // Remainder needs two spare bits over the radicand
  localparam int unsigned REM_BITS = RAD_BITS + 2;

  // Signed exponent with room for subnormal adjust and bias add
  localparam int unsigned EXP_EXT_BITS = EXP_BITS + 2;
  localparam int unsigned EXP_BIAS = 127;

  // Iteration counter, counts 0..ROOT_BITS
  localparam int unsigned COUNT_BITS = 5;

  // Quiet NaN with positive sign and only the top fraction bit set
  localparam logic [31:0] CANONICAL_NAN = 32'h7FC0_0000;

  // ==========================================================
  // Types
  // ==========================================================

  typedef struct packed {
    logic                 sign;
    logic [EXP_BITS-1:0]  exp;
    logic [FRAC_BITS-1:0] frac;
  } fp32_t;

  // Accrued exception flags, RISC-V fflags order
  typedef struct packed {
    logic nv;
    logic dz;
    logic of;
    logic uf;
    logic nx;
  } fp_flags_t;

  typedef enum logic [2:0] {
    RNE = 3'd0,
    RTZ = 3'd1,
    RDN = 3'd2,
    RUP = 3'd3,
    RMM = 3'd4
  } round_mode_e;

  typedef enum logic [2:0] {
    IDLE,
    PREP,
    COMPUTE,
    ROUND,
    DONE
  } sqrt_state_e;

  // Scaled mantissa in [1,4) and the halved biased exponent
  typedef struct packed {
    logic [MANT_BITS:0]      mant;
    logic [EXP_EXT_BITS-1:0] exp;
  } sqrt_job_t;

  // Early-out result for NaN, negative, inf and zero operands
  typedef struct packed {
    logic  is_special;
    logic  invalid;
    fp32_t result;
  } special_t;

endpackage
